//--- source/axi_bridge_cfg.svh
`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// bus geometry
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// one cache line is a four-beat burst
`define LINE_BEATS 4
`define LINE_W 128

// AXI size code for 4-byte beats
`define AXI_SIZE_WORD 3'b010

// AXI len code of a line burst, beats minus one
`define BURST_LEN 8'd3

// reset values
`define BRIDGE_RST_STATE IDLE
`define BEAT_RST_IDX 2'd0

`endif

//--- source/axi_bus_pkg.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

package axi_bus_pkg;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_DATA_W-1:0] word_t;
    typedef logic [`AXI_DATA_W/8-1:0] strb_t;
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;

    // read address channel payload
    typedef struct packed {
        addr_t addr;
        len_t  len;
        size_t size;
    } ar_chan_t;

    // write address channel, same fields as AR
    typedef struct packed {
        addr_t addr;
        len_t  len;
        size_t size;
    } aw_chan_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } w_chan_t;

    // response code not carried, the bridge ignores it
    typedef struct packed {
        word_t data;
        logic  last;
    } r_chan_t;

endpackage

`default_nettype wire

//--- source/cache_req_pkg.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

package cache_req_pkg;

    import axi_bus_pkg::*;

    typedef logic [`LINE_W-1:0] line_t;
    typedef logic [$clog2(`LINE_BEATS)-1:0] beat_idx_t;

    // one request from the data cache
    typedef struct packed {
        addr_t addr;
        logic  write;
        logic  line;
        strb_t strb;
    } cache_req_t;

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } bridge_state_t;

endpackage

`default_nettype wire

//--- source/bridge_ctrl_fsm.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

module bridge_ctrl_fsm
    import axi_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    input  wire             req_valid_i,
    input  wire cache_req_t req_i,
    output logic            req_ready_o,
    output logic            arvalid_o,
    input  wire             arready_i,
    output ar_chan_t        ar_o,
    input  wire             rvalid_i,
    input  wire r_chan_t    r_i,
    output logic            rready_o,
    output logic            awvalid_o,
    input  wire             awready_i,
    output aw_chan_t        aw_o,
    output logic            wvalid_o,
    input  wire             wready_i,
    output logic            wlast_o,
    input  wire             bvalid_i,
    output logic            bready_o,
    input  wire             beat_last_i,
    output logic            beat_clear_o,
    output logic            line_load_o,
    output logic            done_o,
    output strb_t           wstrb_o
);

    bridge_state_t state_q;
    addr_t         addr_q;
    len_t          len_q;
    strb_t         strb_q;
    beat_idx_t     w_left_q;
    logic          done_q;
    logic          accept;

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i && req_ready_o;

    // request payload, held for the whole transaction
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= req_i.addr;
            len_q  <= req_i.line ? `BURST_LEN : '0;
            strb_q <= req_i.line ? '1 : req_i.strb;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q  <= `BRIDGE_RST_STATE;
            w_left_q <= `BEAT_RST_IDX;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= req_i.write ? WR_ADDR : RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready_i) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rvalid_i && beat_last_i) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                WR_ADDR: begin
                    if (awready_i) begin
                        state_q  <= WR_DATA;
                        w_left_q <= beat_idx_t'(len_q);
                    end
                end
                WR_DATA: begin
                    if (wready_i) begin
                        if (wlast_o) begin
                            state_q <= WR_RESP;
                        end else begin
                            w_left_q <= w_left_q - 1'b1;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid_i) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign arvalid_o = (state_q == RD_ADDR);
    assign rready_o  = (state_q == RD_DATA);
    assign awvalid_o = (state_q == WR_ADDR);
    assign wvalid_o  = (state_q == WR_DATA);
    assign bready_o  = (state_q == WR_RESP);

    // own count of remaining W beats, checked against the beat counter
    assign wlast_o = wvalid_o && (w_left_q == '0);

    assign ar_o = '{addr: addr_q, len: len_q, size: `AXI_SIZE_WORD};
    assign aw_o = '{addr: addr_q, len: len_q, size: `AXI_SIZE_WORD};

    assign wstrb_o      = strb_q;
    assign beat_clear_o = accept;
    assign line_load_o  = accept && req_i.write;
    assign done_o       = done_q;

    ar_stable_a: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

    wlast_match_a: assert property (@(posedge aclk) disable iff (!aresetn)
        (state_q == WR_DATA) && wready_i |-> wlast_o == beat_last_i);

    rlast_match_a: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid_i && rready_o |-> r_i.last == beat_last_i);

endmodule

`default_nettype wire

//--- source/beat_counter.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

module beat_counter
    import axi_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire       aclk,
    input  wire       aresetn,
    input  wire       clear_i,
    input  wire       step_i,
    input  wire len_t len_i,
    output beat_idx_t beat_idx_o,
    output logic      beat_last_o
);

    beat_idx_t cnt_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cnt_q <= `BEAT_RST_IDX;
        end else if (clear_i) begin
            cnt_q <= `BEAT_RST_IDX;
        end else if (step_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign beat_idx_o = cnt_q;

    // current beat is the last one of the burst
    assign beat_last_o = (len_t'(cnt_q) == len_i);

    // burst overrun, the next step must wait for a new transaction
    no_overrun_a: assert property (@(posedge aclk) disable iff (!aresetn)
        step_i && beat_last_o |=> !step_i throughout clear_i [->1]);

endmodule

`default_nettype wire

//--- source/write_line_shifter.sv
`default_nettype none

module write_line_shifter
    import axi_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire        aclk,
    input  wire        aresetn,
    input  wire        load_i,
    input  wire line_t line_i,
    input  wire        advance_i,
    output word_t      word_o
);

    localparam int WORD_W = $bits(word_t);

    line_t line_q;

    // word 0 goes out first, the rest moves down one slot per W beat
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            line_q <= '0;
        end else if (load_i) begin
            line_q <= line_i;
        end else if (advance_i) begin
            line_q <= {{WORD_W{1'b0}}, line_q[$bits(line_t)-1:WORD_W]};
        end
    end

    assign word_o = line_q[WORD_W-1:0];

endmodule

`default_nettype wire

//--- source/read_line_assembler.sv
`default_nettype none

module read_line_assembler
    import axi_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,
    input  wire            clear_i,
    input  wire            beat_valid_i,
    input  wire beat_idx_t beat_idx_i,
    input  wire word_t     data_i,
    output line_t          line_o
);

    localparam int WORD_W = $bits(word_t);

    line_t line_q;

    // slots not written by a single read stay zero
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            line_q <= '0;
        end else if (clear_i) begin
            line_q <= '0;
        end else if (beat_valid_i) begin
            line_q[beat_idx_i*WORD_W +: WORD_W] <= data_i;
        end
    end

    assign line_o = line_q;

endmodule

`default_nettype wire

//--- source/axi_bridge_top.sv
`default_nettype none

module axi_bridge_top
    import axi_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    input  wire             req_valid_i,
    input  wire cache_req_t req_i,
    input  wire line_t      wr_line_i,
    output wire             req_ready_o,
    output wire             done_o,
    output wire line_t      rd_line_o,
    output wire ar_chan_t   ar_o,
    output wire             arvalid_o,
    input  wire             arready_i,
    input  wire r_chan_t    r_i,
    input  wire             rvalid_i,
    output wire             rready_o,
    output wire aw_chan_t   aw_o,
    output wire             awvalid_o,
    input  wire             awready_i,
    output wire w_chan_t    w_o,
    output wire             wvalid_o,
    input  wire             wready_i,
    input  wire             bvalid_i,
    output wire             bready_o
);

    wire            beat_last;
    wire            beat_clear;
    wire            line_load;
    wire beat_idx_t beat_idx;
    wire            w_fire = wvalid_o && wready_i;
    wire            r_fire = rvalid_i && rready_o;

    bridge_ctrl_fsm bridge_ctrl_fsm_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .ar_o         (ar_o),
        .rvalid_i     (rvalid_i),
        .r_i          (r_i),
        .rready_o     (rready_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .aw_o         (aw_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .wlast_o      (w_o.last),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .beat_last_i  (beat_last),
        .beat_clear_o (beat_clear),
        .line_load_o  (line_load),
        .done_o       (done_o),
        .wstrb_o      (w_o.strb)
    );

    // one counter serves both directions, only one burst is in flight
    beat_counter beat_counter_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .clear_i     (beat_clear),
        .step_i      (w_fire || r_fire),
        .len_i       (ar_o.len),
        .beat_idx_o  (beat_idx),
        .beat_last_o (beat_last)
    );

    write_line_shifter write_line_shifter_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .load_i    (line_load),
        .line_i    (wr_line_i),
        .advance_i (w_fire),
        .word_o    (w_o.data)
    );

    read_line_assembler read_line_assembler_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .clear_i      (beat_clear),
        .beat_valid_i (r_fire),
        .beat_idx_i   (beat_idx),
        .data_i       (r_i.data),
        .line_o       (rd_line_o)
    );

endmodule

`default_nettype wire

//--- verif/axi_slave_model.sv
`default_nettype none

module axi_slave_model
    import axi_bus_pkg::*;
(
    input  wire           aclk,
    input  wire           aresetn,
    input  wire ar_chan_t ar_i,
    input  wire           arvalid_i,
    output logic          arready_o,
    output r_chan_t       r_o,
    output logic          rvalid_o,
    input  wire           rready_i,
    input  wire aw_chan_t aw_i,
    input  wire           awvalid_i,
    output logic          awready_o,
    input  wire w_chan_t  w_i,
    input  wire           wvalid_i,
    output logic          wready_o,
    output logic          bvalid_o,
    input  wire           bready_i
);

    word_t       mem [0:63];
    logic [31:0] rng_q;
    logic [1:0]  gap_q;
    logic        rd_busy_q;
    logic        wr_busy_q;
    logic        b_pend_q;
    logic [5:0]  rd_idx_q;
    logic [5:0]  wr_idx_q;
    logic [1:0]  rd_left_q;
    logic        ar_fire;
    logic        aw_fire;
    logic        w_fire;
    logic        r_fire;
    logic        b_fire;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every offer waits out the gap left by the previous handshake
    assign arready_o = (gap_q == 2'd0) && !rd_busy_q && !wr_busy_q && !b_pend_q;
    assign awready_o = arready_o;
    assign wready_o  = (gap_q == 2'd0) && wr_busy_q;
    assign rvalid_o  = (gap_q == 2'd0) && rd_busy_q;
    assign bvalid_o  = (gap_q == 2'd0) && b_pend_q;
    assign r_o.data  = mem[rd_idx_q];
    assign r_o.last  = (rd_left_q == 2'd0);

    assign ar_fire = arvalid_i && arready_o;
    assign aw_fire = awvalid_i && awready_o;
    assign w_fire  = wvalid_i && wready_o;
    assign r_fire  = rvalid_o && rready_i;
    assign b_fire  = bvalid_o && bready_i;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rng_q     <= 32'he200;
            gap_q     <= 2'd0;
            rd_busy_q <= 1'b0;
            wr_busy_q <= 1'b0;
            b_pend_q  <= 1'b0;
            rd_idx_q  <= '0;
            wr_idx_q  <= '0;
            rd_left_q <= '0;
        end else begin
            if (ar_fire || aw_fire || w_fire || r_fire || b_fire) begin
                rng_q <= next_rand(rng_q);
                gap_q <= rng_q[1:0];
            end else if (gap_q != 2'd0) begin
                gap_q <= gap_q - 1'b1;
            end
            if (ar_fire) begin
                rd_busy_q <= 1'b1;
                rd_idx_q  <= ar_i.addr[7:2];
                rd_left_q <= ar_i.len[1:0];
            end
            if (r_fire) begin
                rd_idx_q  <= rd_idx_q + 1'b1;
                rd_left_q <= rd_left_q - 1'b1;
                rd_busy_q <= (rd_left_q != 2'd0);
            end
            if (aw_fire) begin
                wr_busy_q <= 1'b1;
                wr_idx_q  <= aw_i.addr[7:2];
            end
            if (w_fire) begin
                wr_idx_q  <= wr_idx_q + 1'b1;
                wr_busy_q <= !w_i.last;
                b_pend_q  <= w_i.last;
            end
            if (b_fire) begin
                b_pend_q <= 1'b0;
            end
        end
    end

    // byte merge into the backing memory
    always @(posedge aclk) begin
        if (aresetn && w_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (w_i.strb[b]) begin
                    mem[wr_idx_q][8*b +: 8] <= w_i.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_axi_bridge.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

module tb_axi_bridge
    import axi_bus_pkg::*;
    import cache_req_pkg::*;
();

    localparam int TIMEOUT = 300;

    logic        aclk;
    logic        aresetn;
    logic        req_valid;
    cache_req_t  req;
    line_t       wr_line;
    logic        req_ready;
    logic        done;
    line_t       rd_line;
    ar_chan_t    ar;
    logic        arvalid;
    logic        arready;
    r_chan_t     r;
    logic        rvalid;
    logic        rready;
    aw_chan_t    aw;
    logic        awvalid;
    logic        awready;
    w_chan_t     w;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    word_t       ref_mem [0:63];
    line_t       exp_lines [$];
    addr_t       exp_addrs [$];
    len_t        exp_lens [$];
    logic        in_flight;
    logic        rd_pending;
    logic [31:0] rng;
    int          err_cnt;

    axi_bridge_top axi_bridge_top_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_valid_i (req_valid),
        .req_i       (req),
        .wr_line_i   (wr_line),
        .req_ready_o (req_ready),
        .done_o      (done),
        .rd_line_o   (rd_line),
        .ar_o        (ar),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .r_i         (r),
        .rvalid_i    (rvalid),
        .rready_o    (rready),
        .aw_o        (aw),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .w_o         (w),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .bvalid_i    (bvalid),
        .bready_o    (bready)
    );

    axi_slave_model axi_slave_model_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ar_i      (ar),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .r_o       (r),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .aw_i      (aw),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .w_i       (w),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bready_i  (bready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t fill_word(input int idx);
        return 32'h3c5a_0000 ^ (idx * 32'h0102_0409);
    endfunction

    function automatic cache_req_t make_req(input addr_t a, input logic wr, input logic ln,
                                            input strb_t s);
        cache_req_t rq;
        rq.addr  = a;
        rq.write = wr;
        rq.line  = ln;
        rq.strb  = s;
        return rq;
    endfunction

    // AXI len is the beat count minus one
    function automatic len_t burst_len_code(input logic ln);
        int beats;
        beats = ln ? `LINE_BEATS : 1;
        return len_t'(beats - 1);
    endfunction

    // expected read line, slots a single read does not fill stay zero
    function automatic line_t expected_line(input cache_req_t rq);
        line_t l;
        int    base;
        l    = '0;
        base = rq.addr[7:2];
        for (int k = 0; k < `LINE_BEATS; k++) begin
            if (rq.line || k == 0) begin
                l[32*k +: 32] = ref_mem[(base + k) % 64];
            end
        end
        return l;
    endfunction

    task automatic apply_write(input cache_req_t rq, input line_t l);
        int base;
        base = rq.addr[7:2];
        for (int k = 0; k < `LINE_BEATS; k++) begin
            for (int b = 0; b < 4; b++) begin
                if (rq.line || (k == 0 && rq.strb[b])) begin
                    ref_mem[(base + k) % 64][8*b +: 8] = l[32*k + 8*b +: 8];
                end
            end
        end
    endtask

    task automatic check_value(input logic [`LINE_W-1:0] got, input logic [`LINE_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic run_request(input cache_req_t rq, input line_t l);
        int n;
        exp_addrs.push_back(rq.addr);
        exp_lens.push_back(burst_len_code(rq.line));
        if (rq.write) begin
            apply_write(rq, l);
        end else begin
            exp_lines.push_back(expected_line(rq));
        end
        @(posedge aclk);
        req_valid <= 1'b1;
        req       <= rq;
        wr_line   <= l;
        n = 0;
        @(negedge aclk);
        while (!req_ready && n < TIMEOUT) begin
            n++;
            @(negedge aclk);
        end
        if (!req_ready) begin
            report_timeout("req_ready");
        end
        @(posedge aclk);
        req_valid <= 1'b0;
        n = 0;
        @(negedge aclk);
        while (!done && n < TIMEOUT) begin
            n++;
            @(negedge aclk);
        end
        if (!done) begin
            report_timeout("done");
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // compare process, sampled mid-cycle
    always @(negedge aclk) begin
        if (aresetn) begin
            if (in_flight && !done) begin
                check_value(req_ready, 1'b0, "req_ready during a transaction");
            end
            // size code 2 means 4-byte beats
            if (arvalid && arready) begin
                check_value(ar.addr, exp_addrs.pop_front(), "AR address");
                check_value(ar.len, exp_lens.pop_front(), "AR len");
                check_value(ar.size, 3'd2, "AR size");
                rd_pending = 1'b1;
            end
            if (awvalid && awready) begin
                check_value(aw.addr, exp_addrs.pop_front(), "AW address");
                check_value(aw.len, exp_lens.pop_front(), "AW len");
                check_value(aw.size, 3'd2, "AW size");
            end
            if (done) begin
                in_flight = 1'b0;
                if (rd_pending) begin
                    check_value(rd_line, exp_lines.pop_front(), "read line");
                    rd_pending = 1'b0;
                end
            end
            if (req_valid && req_ready) begin
                in_flight = 1'b1;
            end
        end
    end

    initial begin
        cache_req_t rq;
        line_t      l;
        aresetn    = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        wr_line    = '0;
        err_cnt    = 0;
        in_flight  = 1'b0;
        rd_pending = 1'b0;
        rng        = 32'he200;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = fill_word(i);
            axi_slave_model_inst.mem[i] <= fill_word(i);
        end
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        check_value(req_ready, 1'b1, "req_ready after reset");
        check_value({arvalid, awvalid, wvalid, rready, bready, done}, '0, "idle outputs");

        // single word, then strobed merge
        run_request(make_req(32'h10, 1'b1, 1'b0, 4'hf), {96'h0, 32'hcafe_f00d});
        run_request(make_req(32'h10, 1'b0, 1'b0, 4'h0), '0);
        run_request(make_req(32'h24, 1'b1, 1'b0, 4'b0101), {96'h0, 32'h1122_3344});
        run_request(make_req(32'h24, 1'b0, 1'b0, 4'h0), '0);

        // full line
        run_request(make_req(32'h40, 1'b1, 1'b1, 4'h0),
                    128'hdddd_4444_cccc_3333_bbbb_2222_aaaa_1111);
        run_request(make_req(32'h40, 1'b0, 1'b1, 4'h0), '0);

        for (int t = 0; t < 40; t++) begin
            rng = xorshift32(rng);
            rq  = make_req({24'h0, rng[19:14], 2'b00}, rng[0], rng[1], rng[11:8]);
            if (rq.line) begin
                rq.addr[3:2] = 2'b00;
            end
            for (int k = 0; k < `LINE_BEATS; k++) begin
                rng = xorshift32(rng);
                l[32*k +: 32] = rng;
            end
            run_request(rq, l);
        end

        @(negedge aclk);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+source
source/axi_bus_pkg.sv
source/cache_req_pkg.sv
source/bridge_ctrl_fsm.sv
source/beat_counter.sv
source/write_line_shifter.sv
source/read_line_assembler.sv
source/axi_bridge_top.sv
verif/axi_slave_model.sv
verif/tb_axi_bridge.sv
